// ==== logic/mips_isa_pkg.sv ====
package mips_isa_pkg;

    // primary opcode field, bits 31:26 of the instruction.
    typedef enum logic [5:0] {
        OP_LB = 6'b100000,
        OP_LW = 6'b100011,
        OP_SB = 6'b101000,
        OP_SW = 6'b101011
    } opcode_t;

    // one data word, seen whole or as four byte lanes.
    // lane n holds address offset n (little-endian lanes).
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } data_word_u;

    // processor side request, held steady while stalled.
    typedef struct packed {
        opcode_t    opcode; // 6 bits.
        logic [31:0] addr;  // byte address.
        data_word_u wdata;  // store data, low byte used by sb.
    } mem_req_t;

endpackage

// ==== logic/cache_pkg.sv ====
package cache_pkg;

    localparam int DEFAULT_INDEX_BITS  = 4; // 16 lines.
    localparam int DEFAULT_MEM_LATENCY = 4; // cycles to read data.

    // 32 address bits less byte offset and index.
    localparam int TAG_BITS = 32 - 2 - DEFAULT_INDEX_BITS;

    // cache control states.
    typedef enum logic [1:0] {
        CU_IDLE       = 2'b00,
        CU_WRITE_BACK = 2'b01,
        CU_REFILL     = 2'b10
    } cu_state_t;

    // one cache line, one word wide.
    typedef struct packed {
        logic                       valid;
        logic                       dirty;
        logic [TAG_BITS-1:0]        tag;
        mips_isa_pkg::data_word_u   data;
    } line_entry_t;

endpackage

// ==== logic/cache_cu.sv ====
module cache_cu #(
    parameter int MEM_LATENCY = cache_pkg::DEFAULT_MEM_LATENCY
) (
    input  logic                  clk,
    input  logic                  rst_b,
    input  mips_isa_pkg::opcode_t opcode,
    input  logic                  hit,
    input  logic                  dirty,
    output logic                  cache_we,
    output logic                  cache_in_select,
    output logic                  mem_we,
    output logic                  mem_in_select,
    output logic                  reg_write_enable,
    output logic                  busy
);

    localparam int CNT_W = $clog2(MEM_LATENCY + 1);
    localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(MEM_LATENCY);

    cache_pkg::cu_state_t state;
    cache_pkg::cu_state_t next_state;
    logic [CNT_W-1:0]     counter;
    logic                 is_mem_op;
    logic                 is_load;
    logic                 last_count;

    assign is_mem_op = (opcode == mips_isa_pkg::OP_LW) ||
                       (opcode == mips_isa_pkg::OP_LB) ||
                       (opcode == mips_isa_pkg::OP_SW) ||
                       (opcode == mips_isa_pkg::OP_SB);

    assign is_load = (opcode == mips_isa_pkg::OP_LW) ||
                     (opcode == mips_isa_pkg::OP_LB);

    assign last_count = (counter == LAST_COUNT);
    assign busy       = (state != cache_pkg::CU_IDLE);

    always_comb begin
        next_state       = state;
        cache_we         = 1'b0;
        cache_in_select  = 1'b0;
        mem_we           = 1'b0;
        mem_in_select    = 1'b0;
        reg_write_enable = 1'b0;

        case (state)
            cache_pkg::CU_IDLE: begin
                if (is_mem_op) begin
                    if (hit) begin
                        if (is_load) begin
                            reg_write_enable = 1'b1; // rdata is valid now.
                        end else begin
                            cache_we        = 1'b1; // lands on the next edge.
                            cache_in_select = 1'b1;
                        end
                    end else if (dirty) begin
                        next_state = cache_pkg::CU_WRITE_BACK;
                    end else begin
                        next_state = cache_pkg::CU_REFILL;
                    end
                end
            end

            cache_pkg::CU_WRITE_BACK: begin
                // victim goes out on the first cycle only.
                if (counter == '0) begin
                    mem_we        = 1'b1;
                    mem_in_select = 1'b1;
                end
                if (last_count) begin
                    next_state = cache_pkg::CU_REFILL;
                end
            end

            cache_pkg::CU_REFILL: begin
                if (last_count) begin
                    cache_we   = 1'b1; // memory word, dirty cleared.
                    next_state = cache_pkg::CU_IDLE;
                end
            end

            default: begin
                next_state = cache_pkg::CU_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state   <= cache_pkg::CU_IDLE;
            counter <= '0;
        end else begin
            state <= next_state;
            if ((next_state != state) || (state == cache_pkg::CU_IDLE)) begin
                counter <= '0; // restart on every state change.
            end else begin
                counter <= counter + 1'b1;
            end
        end
    end

endmodule

// ==== logic/cache_store.sv ====
module cache_store #(
    parameter int INDEX_BITS = cache_pkg::DEFAULT_INDEX_BITS
) (
    input  logic                     clk,
    input  logic                     rst_b,
    input  logic [31:0]              addr,
    input  mips_isa_pkg::data_word_u wdata,
    input  logic                     byte_op,
    input  logic                     cache_we,
    input  logic                     cache_in_select,
    input  mips_isa_pkg::data_word_u mem_data,
    output logic                     hit,
    output logic                     dirty,
    output mips_isa_pkg::data_word_u rd_word,
    output logic [31:0]              victim_addr
);

    localparam int LINES = 2 ** INDEX_BITS;
    localparam int TAG_W = cache_pkg::TAG_BITS;

    cache_pkg::line_entry_t   lines [LINES];
    cache_pkg::line_entry_t   cur_line;
    cache_pkg::line_entry_t   new_line;
    mips_isa_pkg::data_word_u merged;
    logic [INDEX_BITS-1:0]    index;
    logic [TAG_W-1:0]         req_tag;

    assign index   = addr[INDEX_BITS+1:2];
    assign req_tag = TAG_W'(addr >> (INDEX_BITS + 2));

    assign cur_line = lines[index];
    assign hit      = cur_line.valid && (cur_line.tag == req_tag);
    assign dirty    = cur_line.valid && cur_line.dirty;
    assign rd_word  = cur_line.data; // also the write-back data.

    // rebuild the address the resident line came from.
    assign victim_addr = (32'(cur_line.tag) << (INDEX_BITS + 2)) |
                         (32'(index) << 2);

    // sb puts the low byte of the store data into its lane.
    always_comb begin
        merged = cur_line.data;
        if (byte_op) begin
            merged.bytes[addr[1:0]] = wdata.bytes[0];
        end else begin
            merged = wdata;
        end
    end

    always_comb begin
        new_line.valid = 1'b1;
        new_line.tag   = req_tag;
        if (cache_in_select) begin
            new_line.dirty = 1'b1; // processor store.
            new_line.data  = merged;
        end else begin
            new_line.dirty = 1'b0; // refill from memory.
            new_line.data  = mem_data;
        end
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            for (int i = 0; i < LINES; i++) begin
                lines[i].valid <= 1'b0;
            end
        end else if (cache_we) begin
            lines[index] <= new_line;
        end
    end

endmodule

// ==== logic/backing_mem.sv ====
module backing_mem #(
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = cache_pkg::DEFAULT_MEM_LATENCY
) (
    input  logic                     clk,
    input  logic                     rst_b,
    input  logic [31:0]              addr,
    input  logic                     we,
    input  mips_isa_pkg::data_word_u wr_data,
    output mips_isa_pkg::data_word_u rd_data
);

    localparam int WORD_BITS = $clog2(MEM_WORDS);

    typedef mips_isa_pkg::data_word_u word_array_t [MEM_WORDS];

    // every word starts out as its own word index.
    function automatic word_array_t initial_words();
        word_array_t words;
        for (int i = 0; i < MEM_WORDS; i++) begin
            words[i].word = 32'(i);
        end
        return words;
    endfunction

    word_array_t              mem = initial_words();
    mips_isa_pkg::data_word_u pipe [MEM_LATENCY];
    logic [WORD_BITS-1:0]     word_index;

    assign word_index = addr[WORD_BITS+1:2]; // byte offset dropped.

    always_ff @(posedge clk) begin
        if (we) begin
            mem[word_index] <= wr_data;
        end
    end

    // read data walks through MEM_LATENCY stages.
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            for (int i = 0; i < MEM_LATENCY; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= mem[word_index];
            for (int i = 1; i < MEM_LATENCY; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign rd_data = pipe[MEM_LATENCY-1];

endmodule

// ==== logic/data_cache.sv ====
module data_cache #(
    parameter int INDEX_BITS  = cache_pkg::DEFAULT_INDEX_BITS,
    parameter int MEM_LATENCY = cache_pkg::DEFAULT_MEM_LATENCY,
    parameter int MEM_WORDS   = 256
) (
    input  logic                   clk,
    input  logic                   rst_b,
    input  mips_isa_pkg::mem_req_t req,
    output logic [31:0]            rdata,
    output logic                   reg_write_enable,
    output logic                   stall
);

    logic                     is_mem_op;
    logic                     byte_op;
    logic                     hit;
    logic                     dirty;
    logic                     cache_we;
    logic                     cache_in_select;
    logic                     mem_we;
    logic                     mem_in_select;
    logic                     busy;
    logic                     done;
    logic [31:0]              victim_addr;
    logic [31:0]              mem_addr;
    mips_isa_pkg::data_word_u rd_word;
    mips_isa_pkg::data_word_u mem_rd_data;

    assign is_mem_op = (req.opcode == mips_isa_pkg::OP_LW) ||
                       (req.opcode == mips_isa_pkg::OP_LB) ||
                       (req.opcode == mips_isa_pkg::OP_SW) ||
                       (req.opcode == mips_isa_pkg::OP_SB);

    assign byte_op = (req.opcode == mips_isa_pkg::OP_LB) ||
                     (req.opcode == mips_isa_pkg::OP_SB);

    assign mem_addr = mem_in_select ? victim_addr : req.addr;

    // lb returns the addressed byte, zero-extended.
    assign rdata = (req.opcode == mips_isa_pkg::OP_LB) ?
                   {24'h0, rd_word.bytes[req.addr[1:0]]} : rd_word.word;

    // completing cycle is a hit in idle; refill writes happen while busy.
    assign done  = (reg_write_enable || cache_we) && !busy;
    assign stall = is_mem_op && !done;

    cache_cu #(
        .MEM_LATENCY(MEM_LATENCY)
    ) i_cache_cu (
        .clk             (clk),
        .rst_b           (rst_b),
        .opcode          (req.opcode),
        .hit             (hit),
        .dirty           (dirty),
        .cache_we        (cache_we),
        .cache_in_select (cache_in_select),
        .mem_we          (mem_we),
        .mem_in_select   (mem_in_select),
        .reg_write_enable(reg_write_enable),
        .busy            (busy)
    );

    cache_store #(
        .INDEX_BITS(INDEX_BITS)
    ) i_cache_store (
        .clk            (clk),
        .rst_b          (rst_b),
        .addr           (req.addr),
        .wdata          (req.wdata),
        .byte_op        (byte_op),
        .cache_we       (cache_we),
        .cache_in_select(cache_in_select),
        .mem_data       (mem_rd_data),
        .hit            (hit),
        .dirty          (dirty),
        .rd_word        (rd_word),
        .victim_addr    (victim_addr)
    );

    backing_mem #(
        .MEM_WORDS  (MEM_WORDS),
        .MEM_LATENCY(MEM_LATENCY)
    ) i_backing_mem (
        .clk    (clk),
        .rst_b  (rst_b),
        .addr   (mem_addr),
        .we     (mem_we),
        .wr_data(rd_word), // victim word on write-back.
        .rd_data(mem_rd_data)
    );

endmodule

// ==== test/data_cache_tb.sv ====
module data_cache_tb;

    localparam int INDEX_BITS   = 4;
    localparam int MEM_LATENCY  = 4;
    localparam int MEM_WORDS    = 256;
    localparam int LINES        = 2 ** INDEX_BITS;
    localparam int RESET_CYCLES = 8;
    localparam int RANDOM_TESTS = 40;
    localparam int CLK_PERIOD   = 4;
    localparam int WORST_CYCLES = 2 * (MEM_LATENCY + 1) + 2; // dirty miss plus the hit cycle.

    logic                     clk;
    logic                     rst_b;
    mips_isa_pkg::mem_req_t   req;
    logic [31:0]              rdata;
    logic                     reg_write_enable;
    logic                     stall;
    logic                     tests_built;

    mips_isa_pkg::mem_req_t   reqs [$];
    string                    names [$];
    cache_pkg::line_entry_t   model_lines [LINES];
    mips_isa_pkg::data_word_u model_words [MEM_WORDS];
    logic [31:0]              rng_state;

    data_cache #(
        .INDEX_BITS (INDEX_BITS),
        .MEM_LATENCY(MEM_LATENCY),
        .MEM_WORDS  (MEM_WORDS)
    ) i_data_cache (
        .clk             (clk),
        .rst_b           (rst_b),
        .req             (req),
        .rdata           (rdata),
        .reg_write_enable(reg_write_enable),
        .stall           (stall)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic is_load(input mips_isa_pkg::opcode_t op);
        return (op == mips_isa_pkg::OP_LW) || (op == mips_isa_pkg::OP_LB);
    endfunction

    task automatic add_test(input mips_isa_pkg::opcode_t op, input logic [31:0] addr,
                            input logic [31:0] wdata, input string name);
        mips_isa_pkg::mem_req_t r;
        r.opcode     = op;
        r.addr       = addr;
        r.wdata.word = wdata;
        reqs.push_back(r);
        names.push_back(name);
    endtask

    task automatic fail_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input mips_isa_pkg::data_word_u expected,
                              input mips_isa_pkg::data_word_u actual);
        if (actual.word !== expected.word) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected.word, actual.word);
            fail_run();
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("Mismatch in %s: expected %0d cycles, actual %0d cycles",
                     name, expected, actual);
            fail_run();
        end
    endtask

    // reference cache and memory, stepped once per access.
    task automatic model_access(input mips_isa_pkg::mem_req_t r,
                                output mips_isa_pkg::data_word_u exp_data,
                                output int exp_latency);
        int                             idx;
        int                             wi;
        logic [cache_pkg::TAG_BITS-1:0] tag;
        logic                           store;
        idx   = int'(r.addr[INDEX_BITS+1:2]);
        wi    = int'(r.addr >> 2) % MEM_WORDS;
        tag   = r.addr[31:INDEX_BITS+2];
        store = !is_load(r.opcode);
        if (model_lines[idx].valid && (model_lines[idx].tag == tag)) begin
            exp_latency = 0;
        end else begin
            if (model_lines[idx].valid && model_lines[idx].dirty) begin
                exp_latency = 2 * (MEM_LATENCY + 1); // write-back, then refill.
            end else begin
                exp_latency = MEM_LATENCY + 1;
            end
            model_lines[idx].dirty = 1'b0; // refilled line is clean.
        end
        model_lines[idx].valid = 1'b1;
        model_lines[idx].tag   = tag;
        if (store) begin
            model_lines[idx].dirty = 1'b1;
        end
        if (r.opcode == mips_isa_pkg::OP_SW) begin
            model_words[wi] = r.wdata;
        end else if (r.opcode == mips_isa_pkg::OP_SB) begin
            model_words[wi].bytes[r.addr[1:0]] = r.wdata.bytes[0];
        end
        exp_data = model_words[wi];
        if (r.opcode == mips_isa_pkg::OP_LB) begin
            exp_data.word = {24'h0, model_words[wi].bytes[r.addr[1:0]]}; // zero-extended.
        end
    endtask

    initial begin : stimulus
        mips_isa_pkg::data_word_u exp_data;
        mips_isa_pkg::data_word_u act_data;
        mips_isa_pkg::opcode_t    op;
        logic [31:0]              addr;
        int                       exp_latency;
        int                       stall_cycles;
        int                       exp_stall;

        clk         = 1'b0;
        rst_b       = 1'b0;
        req         = '0; // opcode 0 is no memory access.
        tests_built = 1'b0;
        rng_state   = 32'h4e1c;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_words[i].word = 32'(i);
        end
        for (int i = 0; i < LINES; i++) begin
            model_lines[i] = '0;
        end

        add_test(mips_isa_pkg::OP_LW, 32'h000, 32'h0, "lw_cold_000");
        add_test(mips_isa_pkg::OP_LW, 32'h004, 32'h0, "lw_cold_004");
        add_test(mips_isa_pkg::OP_LW, 32'h008, 32'h0, "lw_cold_008");
        add_test(mips_isa_pkg::OP_LW, 32'h000, 32'h0, "lw_hit_000");
        add_test(mips_isa_pkg::OP_LW, 32'h004, 32'h0, "lw_hit_004");
        add_test(mips_isa_pkg::OP_SW, 32'h010, 32'hdeadbeef, "sw_miss_010");
        add_test(mips_isa_pkg::OP_LW, 32'h010, 32'h0, "lw_after_sw_010");
        add_test(mips_isa_pkg::OP_SB, 32'h021, 32'h0000005a, "sb_lane1_021");
        add_test(mips_isa_pkg::OP_LB, 32'h021, 32'h0, "lb_after_sb_021");
        add_test(mips_isa_pkg::OP_LW, 32'h020, 32'h0, "lw_merged_020");
        add_test(mips_isa_pkg::OP_LB, 32'h023, 32'h0, "lb_untouched_023");
        add_test(mips_isa_pkg::OP_LW, 32'h050, 32'h0, "lw_evict_dirty_050");
        add_test(mips_isa_pkg::OP_LW, 32'h010, 32'h0, "lw_written_back_010");
        add_test(mips_isa_pkg::OP_SB, 32'h0a2, 32'h00000077, "sb_evict_dirty_0a2");
        add_test(mips_isa_pkg::OP_LW, 32'h020, 32'h0, "lw_evict_sb_020");
        add_test(mips_isa_pkg::OP_LB, 32'h0a2, 32'h0, "lb_written_back_0a2");
        add_test(mips_isa_pkg::OP_SW, 32'h004, 32'h12345678, "sw_hit_004");
        add_test(mips_isa_pkg::OP_LW, 32'h004, 32'h0, "lw_after_sw_hit_004");

        // four tags over four indexes, so conflicts come often.
        for (int n = 0; n < RANDOM_TESTS; n++) begin
            rng_state = next_random(rng_state);
            case (rng_state[1:0])
                2'd0: op = mips_isa_pkg::OP_LW;
                2'd1: op = mips_isa_pkg::OP_LB;
                2'd2: op = mips_isa_pkg::OP_SW;
                default: op = mips_isa_pkg::OP_SB;
            endcase
            addr = (32'(rng_state[9:8]) << 6) | (32'(rng_state[5:4]) << 2);
            if ((op == mips_isa_pkg::OP_LB) || (op == mips_isa_pkg::OP_SB)) begin
                addr = addr | 32'(rng_state[7:6]);
            end
            rng_state = next_random(rng_state);
            add_test(op, addr, rng_state, $sformatf("random_%0d", n));
        end
        tests_built = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_b = 1'b1;
        #1;
        if (stall || reg_write_enable) begin
            $display("stall or reg_write_enable is high right after reset");
            fail_run();
        end

        for (int i = 0; i < reqs.size(); i++) begin
            @(posedge clk);
            #1;
            req = reqs[i];
            model_access(reqs[i], exp_data, exp_latency);
            stall_cycles = 0;
            #1;
            while (stall) begin
                stall_cycles++;
                @(posedge clk);
                #2;
            end
            // a miss also stalls in the cycle that detects it.
            exp_stall = (exp_latency == 0) ? 0 : exp_latency + 1;
            check_latency(names[i], exp_stall, stall_cycles);
            if (is_load(reqs[i].opcode)) begin
                if (!reg_write_enable) begin
                    $display("reg_write_enable stayed low when %s completed", names[i]);
                    fail_run();
                end
                act_data.word = rdata;
                check_word(names[i], exp_data, act_data);
            end
        end

        @(posedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (tests_built);
        limit = (reqs.size() * WORST_CYCLES + RESET_CYCLES + 2) * CLK_PERIOD;
        #(limit);
        $display("timeout: the cache never finished its accesses");
        fail_run();
    end

endmodule

// ==== data_cache.f ====
logic/mips_isa_pkg.sv
logic/cache_pkg.sv
logic/cache_cu.sv
logic/cache_store.sv
logic/backing_mem.sv
logic/data_cache.sv
test/data_cache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" &&
verilator --binary -j 0 --top-module data_cache_tb -f data_cache.f &&
./obj_dir/Vdata_cache_tb | grep "TEST RESULT: PASS" ||
{ echo "simulation failed"; exit 1; }
